// ==== logic/tmu_defs.svh ====
// texture mapping unit vertical span stage
// widths of the datapath and the legal texture bounds
`ifndef TMU_DEFS_SVH
`define TMU_DEFS_SVH

// texture coordinates, signed fixed point with 6 fraction bits
`define TMU_TC_W 18
// destination pixel coordinates
`define TMU_DC_W 12
// points per span
`define TMU_CNT_W 11
// edge quotient and remainder
`define TMU_Q_W 17
// 512 x 256 texture, last texel plus fraction
`define TMU_TEX_MAX_X 32767
`define TMU_TEX_MAX_Y 16383
`endif

// ==== logic/tmu_pkg.sv ====
// texture mapping unit types
// coordinate, count and FSM state types shared by the span stage
`include "tmu_defs.svh"

package tmu_pkg;
	typedef logic signed [`TMU_TC_W-1:0] tcoord_t;
	typedef logic [`TMU_DC_W-1:0] dcoord_t;
	typedef logic [`TMU_CNT_W-1:0] count_t;
	typedef logic [`TMU_Q_W-1:0] qr_t;

	// vertical walk controller
	typedef enum logic {VI_IDLE, VI_BUSY} vi_state_t;

	// edge setup sequencer
	typedef enum logic [1:0] {SU_IDLE, SU_DIV, SU_DONE} setup_state_t;

endpackage

// ==== logic/tmu_edge_setup.sv ====
// edge setup
// latches a span request and divides the four edge differences by the
// point count, one shared restoring divider, one quotient bit per cycle
`include "tmu_defs.svh"

module tmu_edge_setup (
	input  logic               sys_clk,
	input  logic               sys_rst,
	input  logic               pipe_stb_i,
	output logic               pipe_ack_o,
	output logic               busy,
	input  tmu_pkg::tcoord_t   ax,
	input  tmu_pkg::tcoord_t   ay,
	input  tmu_pkg::tcoord_t   bx,
	input  tmu_pkg::tcoord_t   by,
	input  tmu_pkg::tcoord_t   cx,
	input  tmu_pkg::tcoord_t   cy,
	input  tmu_pkg::tcoord_t   dx,
	input  tmu_pkg::tcoord_t   dy,
	input  tmu_pkg::dcoord_t   drx,
	input  tmu_pkg::dcoord_t   dry,
	input  tmu_pkg::count_t    dst_squareh,
	output logic               setup_stb,
	input  logic               setup_ack,
	output tmu_pkg::tcoord_t   ax_o,
	output tmu_pkg::tcoord_t   ay_o,
	output tmu_pkg::tcoord_t   bx_o,
	output tmu_pkg::tcoord_t   by_o,
	output logic               diff_cx_positive,
	output tmu_pkg::qr_t       diff_cx_q,
	output tmu_pkg::qr_t       diff_cx_r,
	output logic               diff_cy_positive,
	output tmu_pkg::qr_t       diff_cy_q,
	output tmu_pkg::qr_t       diff_cy_r,
	output logic               diff_dx_positive,
	output tmu_pkg::qr_t       diff_dx_q,
	output tmu_pkg::qr_t       diff_dx_r,
	output logic               diff_dy_positive,
	output tmu_pkg::qr_t       diff_dy_q,
	output tmu_pkg::qr_t       diff_dy_r,
	output tmu_pkg::dcoord_t   drx_o,
	output tmu_pkg::dcoord_t   dry_o,
	output tmu_pkg::count_t    squareh_o
);
	tmu_pkg::setup_state_t state;
	tmu_pkg::tcoord_t cx_l, cy_l, dx_l, dy_l;
	tmu_pkg::tcoord_t diff_sel;
	tmu_pkg::qr_t mag_sel, dvd_in, rem_in, dvd, rem_q, q_next;
	logic [`TMU_TC_W-1:0] mag_full;
	logic [`TMU_Q_W:0] trial, div_ext, rem_next;
	logic [1:0] chan;
	logic [4:0] bit_cnt;
	logic pos_sel, trial_ge, step_last;

	assign pipe_ack_o = (state == tmu_pkg::SU_IDLE);
	assign busy = (state != tmu_pkg::SU_IDLE);
	assign setup_stb = (state == tmu_pkg::SU_DONE);

	// end minus start of the channel being divided
	always_comb begin
		case (chan)
			2'd0: diff_sel = cx_l - ax_o;
			2'd1: diff_sel = cy_l - ay_o;
			2'd2: diff_sel = dx_l - bx_o;
			default: diff_sel = dy_l - by_o;
		endcase
	end

	assign pos_sel = ~diff_sel[`TMU_TC_W-1];
	assign mag_full = pos_sel ? diff_sel : -diff_sel;
	// magnitude kept to the quotient width
	assign mag_sel = mag_full[`TMU_Q_W-1:0];

	// first bit of a channel starts from the fresh magnitude and zero remainder
	assign dvd_in = (bit_cnt == 5'd0) ? mag_sel : dvd;
	assign rem_in = (bit_cnt == 5'd0) ? '0 : rem_q;
	assign trial = {rem_in, dvd_in[`TMU_Q_W-1]};
	assign div_ext = {{(`TMU_Q_W+1-`TMU_CNT_W){1'b0}}, squareh_o};
	assign trial_ge = (trial >= div_ext);
	assign rem_next = trial_ge ? trial - div_ext : trial;
	assign q_next = {dvd_in[`TMU_Q_W-2:0], trial_ge};
	assign step_last = (state == tmu_pkg::SU_DIV) && (bit_cnt == 5'(`TMU_Q_W - 1));

	// sequencer
	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			state <= tmu_pkg::SU_IDLE;
			chan <= 2'd0;
			bit_cnt <= 5'd0;
		end else begin
			case (state)
				tmu_pkg::SU_IDLE: begin
					chan <= 2'd0;
					bit_cnt <= 5'd0;
					if (pipe_stb_i)
						state <= tmu_pkg::SU_DIV;
				end
				tmu_pkg::SU_DIV: begin
					if (step_last) begin
						bit_cnt <= 5'd0;
						chan <= chan + 2'd1;
						if (chan == 2'd3)
							state <= tmu_pkg::SU_DONE;
					end else begin
						bit_cnt <= bit_cnt + 5'd1;
					end
				end
				tmu_pkg::SU_DONE: begin
					if (setup_ack)
						state <= tmu_pkg::SU_IDLE;
				end
				default: state <= tmu_pkg::SU_IDLE;
			endcase
		end
	end

	// request latch
	always_ff @(posedge sys_clk) begin
		if (pipe_stb_i && pipe_ack_o) begin
			ax_o <= ax;
			ay_o <= ay;
			bx_o <= bx;
			by_o <= by;
			cx_l <= cx;
			cy_l <= cy;
			dx_l <= dx;
			dy_l <= dy;
			drx_o <= drx;
			dry_o <= dry;
			squareh_o <= dst_squareh;
		end
	end

	// divider datapath, quotient shifts in at the bottom of dvd
	always_ff @(posedge sys_clk) begin
		if (state == tmu_pkg::SU_DIV) begin
			dvd <= q_next;
			rem_q <= rem_next[`TMU_Q_W-1:0];
		end
	end

	// result of the last bit goes to its channel
	always_ff @(posedge sys_clk) begin
		if (step_last) begin
			case (chan)
				2'd0: begin
					diff_cx_positive <= pos_sel;
					diff_cx_q <= q_next;
					diff_cx_r <= rem_next[`TMU_Q_W-1:0];
				end
				2'd1: begin
					diff_cy_positive <= pos_sel;
					diff_cy_q <= q_next;
					diff_cy_r <= rem_next[`TMU_Q_W-1:0];
				end
				2'd2: begin
					diff_dx_positive <= pos_sel;
					diff_dx_q <= q_next;
					diff_dx_r <= rem_next[`TMU_Q_W-1:0];
				end
				default: begin
					diff_dy_positive <= pos_sel;
					diff_dy_q <= q_next;
					diff_dy_r <= rem_next[`TMU_Q_W-1:0];
				end
			endcase
		end
	end

endmodule

// ==== logic/tmu_geninterp.sv ====
// error-accumulating linear interpolator
// walks one texture coordinate from init by diff/divisor per point
`include "tmu_defs.svh"

module tmu_geninterp (
	input  logic             sys_clk,
	input  logic             load,
	input  logic             next_point,
	input  tmu_pkg::tcoord_t init,
	input  logic             positive,
	input  tmu_pkg::qr_t     q,
	input  tmu_pkg::qr_t     r,
	input  tmu_pkg::count_t  divisor,
	output tmu_pkg::tcoord_t o
);
	// step parameters held for the whole walk
	logic pos_r;
	tmu_pkg::qr_t q_r, r_r;
	tmu_pkg::count_t div_r;

	tmu_pkg::qr_t err, sum, div_ext;
	logic wrap;
	logic [`TMU_TC_W-1:0] step;

	assign div_ext = {{(`TMU_Q_W-`TMU_CNT_W){1'b0}}, div_r};
	// both terms below the divisor, so the sum cannot overflow
	assign sum = err + r_r;
	assign wrap = (sum >= div_ext);
	// one extra unit when the error wraps
	assign step = {1'b0, q_r} + {{(`TMU_TC_W-1){1'b0}}, wrap};

	always_ff @(posedge sys_clk) begin
		if (load) begin
			pos_r <= positive;
			q_r <= q;
			r_r <= r;
			div_r <= divisor;
		end
	end

	always_ff @(posedge sys_clk) begin
		if (load) begin
			o <= init;
			err <= '0;
		end else if (next_point) begin
			if (pos_r)
				o <= o + $signed(step);
			else
				o <= o - $signed(step);
			// error term stays below the divisor
			err <= wrap ? sum - div_ext : sum;
		end
	end

endmodule

// ==== logic/tmu_vinterp.sv ====
// vertical interpolator
// walks dst_squareh points down one destination column, stepping the
// four texture coordinates with one interpolator each
module tmu_vinterp (
	input  logic             sys_clk,
	input  logic             sys_rst,
	input  logic             setup_stb,
	output logic             setup_ack,
	output logic             busy,
	input  tmu_pkg::tcoord_t ax,
	input  tmu_pkg::tcoord_t ay,
	input  tmu_pkg::tcoord_t bx,
	input  tmu_pkg::tcoord_t by,
	input  logic             diff_cx_positive,
	input  tmu_pkg::qr_t     diff_cx_q,
	input  tmu_pkg::qr_t     diff_cx_r,
	input  logic             diff_cy_positive,
	input  tmu_pkg::qr_t     diff_cy_q,
	input  tmu_pkg::qr_t     diff_cy_r,
	input  logic             diff_dx_positive,
	input  tmu_pkg::qr_t     diff_dx_q,
	input  tmu_pkg::qr_t     diff_dx_r,
	input  logic             diff_dy_positive,
	input  tmu_pkg::qr_t     diff_dy_q,
	input  tmu_pkg::qr_t     diff_dy_r,
	input  tmu_pkg::dcoord_t drx,
	input  tmu_pkg::dcoord_t dry,
	input  tmu_pkg::count_t  squareh,
	output logic             point_stb,
	input  logic             point_ack,
	output tmu_pkg::dcoord_t x,
	output tmu_pkg::dcoord_t y,
	output tmu_pkg::tcoord_t tsx,
	output tmu_pkg::tcoord_t tsy,
	output tmu_pkg::tcoord_t tex,
	output tmu_pkg::tcoord_t tey
);
	tmu_pkg::vi_state_t state, next_state;
	tmu_pkg::count_t remaining;
	logic load, next_point, last_point;

	// channel order cx, cy, dx, dy
	tmu_pkg::tcoord_t init_a [4];
	tmu_pkg::tcoord_t tc_a [4];
	tmu_pkg::qr_t q_a [4];
	tmu_pkg::qr_t r_a [4];
	logic pos_a [4];

	assign init_a = '{ax, ay, bx, by};
	assign pos_a = '{diff_cx_positive, diff_cy_positive, diff_dx_positive, diff_dy_positive};
	assign q_a = '{diff_cx_q, diff_cy_q, diff_dx_q, diff_dy_q};
	assign r_a = '{diff_cx_r, diff_cy_r, diff_dx_r, diff_dy_r};

	for (genvar i = 0; i < 4; i++) begin : g_interp
		tmu_geninterp u_interp (
			.sys_clk    (sys_clk),
			.load       (load),
			.next_point (next_point),
			.init       (init_a[i]),
			.positive   (pos_a[i]),
			.q          (q_a[i]),
			.r          (r_a[i]),
			.divisor    (squareh),
			.o          (tc_a[i])
		);
	end

	assign tsx = tc_a[0];
	assign tsy = tc_a[1];
	assign tex = tc_a[2];
	assign tey = tc_a[3];

	// column stays fixed, row counts up, remaining counts down
	always_ff @(posedge sys_clk) begin
		if (load) begin
			x <= drx;
			y <= dry;
			remaining <= squareh - 1'b1;
		end else if (next_point) begin
			y <= y + 1'b1;
			remaining <= remaining - 1'b1;
		end
	end
	assign last_point = (remaining == '0);

	always_ff @(posedge sys_clk) begin
		if (sys_rst)
			state <= tmu_pkg::VI_IDLE;
		else
			state <= next_state;
	end

	assign setup_ack = (state == tmu_pkg::VI_IDLE);
	assign point_stb = (state == tmu_pkg::VI_BUSY);
	assign busy = point_stb;

	always_comb begin
		next_state = state;
		load = 1'b0;
		next_point = 1'b0;
		case (state)
			tmu_pkg::VI_IDLE: begin
				if (setup_stb) begin
					load = 1'b1;
					next_state = tmu_pkg::VI_BUSY;
				end
			end
			tmu_pkg::VI_BUSY: begin
				// point held until acked
				if (point_ack) begin
					if (last_point)
						next_state = tmu_pkg::VI_IDLE;
					else
						next_point = 1'b1;
				end
			end
			default: next_state = tmu_pkg::VI_IDLE;
		endcase
	end

endmodule

// ==== logic/tmu_coord_clamp.sv ====
// coordinate clamp
// one-entry output register, texture coordinates limited to the texture
`include "tmu_defs.svh"

module tmu_coord_clamp (
	input  logic             sys_clk,
	input  logic             sys_rst,
	input  logic             point_stb,
	output logic             point_ack,
	output logic             busy,
	input  tmu_pkg::dcoord_t x,
	input  tmu_pkg::dcoord_t y,
	input  tmu_pkg::tcoord_t tsx,
	input  tmu_pkg::tcoord_t tsy,
	input  tmu_pkg::tcoord_t tex,
	input  tmu_pkg::tcoord_t tey,
	output logic             pipe_stb_o,
	input  logic             pipe_ack_i,
	output tmu_pkg::dcoord_t x_o,
	output tmu_pkg::dcoord_t y_o,
	output tmu_pkg::tcoord_t tsx_o,
	output tmu_pkg::tcoord_t tsy_o,
	output tmu_pkg::tcoord_t tex_o,
	output tmu_pkg::tcoord_t tey_o
);
	logic valid;

	// negative to zero, above max to max
	function automatic tmu_pkg::tcoord_t clamp_tc(input tmu_pkg::tcoord_t v,
			input tmu_pkg::tcoord_t max_v);
		if (v < 0)
			return '0;
		else if (v > max_v)
			return max_v;
		else
			return v;
	endfunction

	// free slot or slot drains this cycle
	assign point_ack = ~valid | pipe_ack_i;
	assign pipe_stb_o = valid;
	assign busy = valid;

	always_ff @(posedge sys_clk) begin
		if (sys_rst)
			valid <= 1'b0;
		else if (point_stb && point_ack)
			valid <= 1'b1;
		else if (pipe_ack_i)
			valid <= 1'b0;
	end

	always_ff @(posedge sys_clk) begin
		if (point_stb && point_ack) begin
			x_o <= x;
			y_o <= y;
			tsx_o <= clamp_tc(tsx, tmu_pkg::tcoord_t'(`TMU_TEX_MAX_X));
			tsy_o <= clamp_tc(tsy, tmu_pkg::tcoord_t'(`TMU_TEX_MAX_Y));
			tex_o <= clamp_tc(tex, tmu_pkg::tcoord_t'(`TMU_TEX_MAX_X));
			tey_o <= clamp_tc(tey, tmu_pkg::tcoord_t'(`TMU_TEX_MAX_Y));
		end
	end

endmodule

// ==== logic/tmu_vertical.sv ====
// texture mapping unit vertical span stage
// edge setup, vertical interpolator and coordinate clamp in a chain
module tmu_vertical (
	input  logic             sys_clk,
	input  logic             sys_rst,
	input  logic             pipe_stb_i,
	output logic             pipe_ack_o,
	output logic             busy,
	input  tmu_pkg::tcoord_t ax,
	input  tmu_pkg::tcoord_t ay,
	input  tmu_pkg::tcoord_t bx,
	input  tmu_pkg::tcoord_t by,
	input  tmu_pkg::tcoord_t cx,
	input  tmu_pkg::tcoord_t cy,
	input  tmu_pkg::tcoord_t dx,
	input  tmu_pkg::tcoord_t dy,
	input  tmu_pkg::dcoord_t drx,
	input  tmu_pkg::dcoord_t dry,
	input  tmu_pkg::count_t  dst_squareh,
	output logic             pipe_stb_o,
	input  logic             pipe_ack_i,
	output tmu_pkg::dcoord_t x,
	output tmu_pkg::dcoord_t y,
	output tmu_pkg::tcoord_t tsx,
	output tmu_pkg::tcoord_t tsy,
	output tmu_pkg::tcoord_t tex,
	output tmu_pkg::tcoord_t tey
);
	// setup to interpolator
	logic setup_stb, setup_ack;
	tmu_pkg::tcoord_t s_ax, s_ay, s_bx, s_by;
	logic cx_pos, cy_pos, dx_pos, dy_pos;
	tmu_pkg::qr_t cx_q, cx_r, cy_q, cy_r, dx_q, dx_r, dy_q, dy_r;
	tmu_pkg::dcoord_t s_drx, s_dry;
	tmu_pkg::count_t s_squareh;

	// interpolator to clamp
	logic point_stb, point_ack;
	tmu_pkg::dcoord_t p_x, p_y;
	tmu_pkg::tcoord_t p_tsx, p_tsy, p_tex, p_tey;

	logic busy_setup, busy_vi, busy_clamp;

	assign busy = busy_setup | busy_vi | busy_clamp;

	tmu_edge_setup u_setup (
		.sys_clk(sys_clk), .sys_rst(sys_rst),
		.pipe_stb_i(pipe_stb_i), .pipe_ack_o(pipe_ack_o), .busy(busy_setup),
		.ax(ax), .ay(ay), .bx(bx), .by(by), .cx(cx), .cy(cy), .dx(dx), .dy(dy),
		.drx(drx), .dry(dry), .dst_squareh(dst_squareh),
		.setup_stb(setup_stb), .setup_ack(setup_ack),
		.ax_o(s_ax), .ay_o(s_ay), .bx_o(s_bx), .by_o(s_by),
		.diff_cx_positive(cx_pos), .diff_cx_q(cx_q), .diff_cx_r(cx_r),
		.diff_cy_positive(cy_pos), .diff_cy_q(cy_q), .diff_cy_r(cy_r),
		.diff_dx_positive(dx_pos), .diff_dx_q(dx_q), .diff_dx_r(dx_r),
		.diff_dy_positive(dy_pos), .diff_dy_q(dy_q), .diff_dy_r(dy_r),
		.drx_o(s_drx), .dry_o(s_dry), .squareh_o(s_squareh)
	);

	tmu_vinterp u_vinterp (
		.sys_clk(sys_clk), .sys_rst(sys_rst),
		.setup_stb(setup_stb), .setup_ack(setup_ack), .busy(busy_vi),
		.ax(s_ax), .ay(s_ay), .bx(s_bx), .by(s_by),
		.diff_cx_positive(cx_pos), .diff_cx_q(cx_q), .diff_cx_r(cx_r),
		.diff_cy_positive(cy_pos), .diff_cy_q(cy_q), .diff_cy_r(cy_r),
		.diff_dx_positive(dx_pos), .diff_dx_q(dx_q), .diff_dx_r(dx_r),
		.diff_dy_positive(dy_pos), .diff_dy_q(dy_q), .diff_dy_r(dy_r),
		.drx(s_drx), .dry(s_dry), .squareh(s_squareh),
		.point_stb(point_stb), .point_ack(point_ack),
		.x(p_x), .y(p_y), .tsx(p_tsx), .tsy(p_tsy), .tex(p_tex), .tey(p_tey)
	);

	tmu_coord_clamp u_clamp (
		.sys_clk(sys_clk), .sys_rst(sys_rst),
		.point_stb(point_stb), .point_ack(point_ack), .busy(busy_clamp),
		.x(p_x), .y(p_y), .tsx(p_tsx), .tsy(p_tsy), .tex(p_tex), .tey(p_tey),
		.pipe_stb_o(pipe_stb_o), .pipe_ack_i(pipe_ack_i),
		.x_o(x), .y_o(y), .tsx_o(tsx), .tsy_o(tsy), .tex_o(tex), .tey_o(tey)
	);

endmodule

// ==== dv/tmu_vertical_props.sv ====
// handshake and reset assertions for the vertical span stage
// bound into the top level, sees the internal stage links too
module tmu_vertical_props (
	input logic             sys_clk,
	input logic             sys_rst,
	input logic             pipe_ack_o,
	input logic             busy,
	input logic             pipe_stb_o,
	input logic             pipe_ack_i,
	input logic             setup_stb,
	input logic             setup_ack,
	input logic             point_stb,
	input logic             point_ack,
	input tmu_pkg::dcoord_t x,
	input tmu_pkg::dcoord_t y,
	input tmu_pkg::tcoord_t tsx,
	input tmu_pkg::tcoord_t tsy,
	input tmu_pkg::tcoord_t tex,
	input tmu_pkg::tcoord_t tey
);
	timeunit 1ns;
	timeprecision 1ps;

	// all stages idle right after a reset cycle
	reset_idle: assert property (@(posedge sys_clk)
		sys_rst |=> pipe_ack_o && !pipe_stb_o && !busy && !setup_stb && !point_stb)
		else $error("stages not idle after reset");

	// stalled output point keeps its strobe and data
	out_hold: assert property (@(posedge sys_clk) disable iff (sys_rst)
		pipe_stb_o && !pipe_ack_i |=> pipe_stb_o && $stable({x, y, tsx, tsy, tex, tey}))
		else $error("output point changed while stalled");

	// internal links hold their strobe until acked
	setup_hold: assert property (@(posedge sys_clk) disable iff (sys_rst)
		setup_stb && !setup_ack |=> setup_stb)
		else $error("setup strobe dropped before ack");

	point_hold: assert property (@(posedge sys_clk) disable iff (sys_rst)
		point_stb && !point_ack |=> point_stb)
		else $error("point strobe dropped before ack");

endmodule

bind tmu_vertical tmu_vertical_props u_props (
	.sys_clk(sys_clk), .sys_rst(sys_rst),
	.pipe_ack_o(pipe_ack_o), .busy(busy), .pipe_stb_o(pipe_stb_o), .pipe_ack_i(pipe_ack_i),
	.setup_stb(setup_stb), .setup_ack(setup_ack),
	.point_stb(point_stb), .point_ack(point_ack),
	.x(x), .y(y), .tsx(tsx), .tsy(tsy), .tex(tex), .tey(tey)
);

// ==== dv/tmu_vertical_tb.sv ====
// testbench for the texture mapping unit vertical span stage
// random span requests with every output point checked against a reference model
`include "tmu_defs.svh"

module tmu_vertical_tb;
	timeunit 1ns;
	timeprecision 1ps;

	localparam int NUM_REQ = 12;
	localparam int MAX_PTS = 2047;
	localparam int WATCH_CYCLES = NUM_REQ * (80 + MAX_PTS * 4) + 100;

	typedef struct packed {
		tmu_pkg::dcoord_t x;
		tmu_pkg::dcoord_t y;
		tmu_pkg::tcoord_t tsx;
		tmu_pkg::tcoord_t tsy;
		tmu_pkg::tcoord_t tex;
		tmu_pkg::tcoord_t tey;
	} point_t;

	logic sys_clk, sys_rst;
	logic pipe_stb_i, pipe_ack_o, busy, pipe_stb_o, pipe_ack_i;
	tmu_pkg::tcoord_t ax, ay, bx, by, cx, cy, dx, dy;
	tmu_pkg::dcoord_t drx, dry, x, y;
	tmu_pkg::count_t dst_squareh;
	tmu_pkg::tcoord_t tsx, tsy, tex, tey;

	integer seed;
	int tcoord_errs, dcoord_errs, flag_errs, proto_errs;
	// expected points in output order
	point_t exp_q[$];

	tmu_vertical UUT (
		.sys_clk(sys_clk), .sys_rst(sys_rst),
		.pipe_stb_i(pipe_stb_i), .pipe_ack_o(pipe_ack_o), .busy(busy),
		.ax(ax), .ay(ay), .bx(bx), .by(by), .cx(cx), .cy(cy), .dx(dx), .dy(dy),
		.drx(drx), .dry(dry), .dst_squareh(dst_squareh),
		.pipe_stb_o(pipe_stb_o), .pipe_ack_i(pipe_ack_i),
		.x(x), .y(y), .tsx(tsx), .tsy(tsy), .tex(tex), .tey(tey)
	);

	initial sys_clk = 1'b0;
	always #50 sys_clk = ~sys_clk;

	task automatic check_tcoord(string name, tmu_pkg::tcoord_t exp, tmu_pkg::tcoord_t act);
		if (act !== exp) begin
			$display("FAILED at %0d ns: %s expected %0d, got %0d", $time, name, exp, act);
			tcoord_errs++;
		end
	endtask

	task automatic check_dcoord(string name, tmu_pkg::dcoord_t exp, tmu_pkg::dcoord_t act);
		if (act !== exp) begin
			$display("FAILED at %0d ns: %s expected %0d, got %0d", $time, name, exp, act);
			dcoord_errs++;
		end
	endtask

	task automatic check_flag(string name, logic exp, logic act);
		if (act !== exp) begin
			$display("FAILED at %0d ns: %s expected %b, got %b", $time, name, exp, act);
			flag_errs++;
		end
	endtask

	// texture coordinate within +-65535 so every edge difference fits 17 bits
	function automatic tmu_pkg::tcoord_t rand_coord();
		logic [16:0] r;
		r = 17'($random(seed));
		return tmu_pkg::tcoord_t'($signed(r));
	endfunction

	// mode 1 flat, 2 rising, 3 falling, else free
	function automatic tmu_pkg::tcoord_t edge_end(tmu_pkg::tcoord_t start, int mode);
		tmu_pkg::tcoord_t mag;
		mag = tmu_pkg::tcoord_t'($random(seed) & 32'hffff);
		case (mode)
			1: return start;
			2: return start + mag;
			3: return start - mag;
			default: return rand_coord();
		endcase
	endfunction

	// point k lies floor(k*|diff|/n) away from start, toward stop
	function automatic int walk(tmu_pkg::tcoord_t start, tmu_pkg::tcoord_t stop, int k, int n);
		int d, mag, off;
		d = int'(stop) - int'(start);
		mag = (d < 0) ? -d : d;
		off = (k * mag) / n;
		return (d < 0) ? int'(start) - off : int'(start) + off;
	endfunction

	function automatic tmu_pkg::tcoord_t limit(int v, int max_v);
		if (v < 0)
			return '0;
		if (v > max_v)
			return tmu_pkg::tcoord_t'(max_v);
		return tmu_pkg::tcoord_t'(v);
	endfunction

	// expected points of the request now on the inputs
	task automatic push_span();
		point_t p;
		int n;
		n = int'(dst_squareh);
		for (int k = 0; k < n; k++) begin
			p.x = drx;
			p.y = dry + tmu_pkg::dcoord_t'(k);
			p.tsx = limit(walk(ax, cx, k, n), `TMU_TEX_MAX_X);
			p.tsy = limit(walk(ay, cy, k, n), `TMU_TEX_MAX_Y);
			p.tex = limit(walk(bx, dx, k, n), `TMU_TEX_MAX_X);
			p.tey = limit(walk(by, dy, k, n), `TMU_TEX_MAX_Y);
			exp_q.push_back(p);
		end
	endtask

	// one falling edge, new output ack, point on show compared to queue head
	task automatic step_cycle();
		point_t p;
		@(negedge sys_clk);
		pipe_ack_i = ($random(seed) & 3) != 0;
		if (pipe_stb_o) begin
			if (exp_q.size() == 0) begin
				$display("error at %0d ns: point at row %0d with none expected", $time, y);
				proto_errs++;
			end else begin
				p = exp_q[0];
				check_dcoord("x", p.x, x);
				check_dcoord("y", p.y, y);
				check_tcoord("tsx", p.tsx, tsx);
				check_tcoord("tsy", p.tsy, tsy);
				check_tcoord("tex", p.tex, tex);
				check_tcoord("tey", p.tey, tey);
				// transfer happens on the coming rising edge
				if (pipe_ack_i)
					void'(exp_q.pop_front());
			end
		end
	endtask

	task automatic send_request(tmu_pkg::count_t n, int mode);
		step_cycle();
		pipe_stb_i = 1'b1;
		ax = rand_coord();
		ay = rand_coord();
		bx = rand_coord();
		by = rand_coord();
		cx = edge_end(ax, mode);
		cy = edge_end(ay, mode);
		dx = edge_end(bx, mode);
		dy = edge_end(by, mode);
		drx = tmu_pkg::dcoord_t'($random(seed));
		dry = tmu_pkg::dcoord_t'($random(seed));
		dst_squareh = n;
		// request held until setup is idle again
		while (!pipe_ack_o)
			step_cycle();
		push_span();
	endtask

	initial begin
		seed = 32'h1a22_56f7;
		tcoord_errs = 0;
		dcoord_errs = 0;
		flag_errs = 0;
		proto_errs = 0;
		sys_rst = 1'b1;
		pipe_stb_i = 1'b0;
		pipe_ack_i = 1'b1;
		{ax, ay, bx, by, cx, cy, dx, dy} = '0;
		drx = '0;
		dry = '0;
		dst_squareh = '0;
		repeat (5) @(posedge sys_clk);
		@(negedge sys_clk);
		sys_rst = 1'b0;
		check_flag("pipe_stb_o", 1'b0, pipe_stb_o);
		check_flag("busy", 1'b0, busy);
		check_flag("pipe_ack_o", 1'b1, pipe_ack_o);

		// single point, full length rising, flat, falling
		send_request(tmu_pkg::count_t'(1), 0);
		send_request(tmu_pkg::count_t'(MAX_PTS), 2);
		send_request(tmu_pkg::count_t'(7), 1);
		send_request(tmu_pkg::count_t'(300), 3);
		for (int i = 4; i < NUM_REQ; i++)
			send_request(tmu_pkg::count_t'(1 + ($random(seed) & 63)), i % 4);
		step_cycle();
		pipe_stb_i = 1'b0;

		while (busy)
			step_cycle();
		if (exp_q.size() != 0) begin
			$display("error: %0d expected points never came out", exp_q.size());
			proto_errs++;
		end
		// nothing extra may follow
		repeat (20) step_cycle();

		$display("error counts: tcoord %0d, dcoord %0d, flag %0d, protocol %0d",
			tcoord_errs, dcoord_errs, flag_errs, proto_errs);
		if (tcoord_errs + dcoord_errs + flag_errs + proto_errs == 0)
			$display("All checks passed");
		else
			$display("Checks failed");
		$finish;
	end

	// watchdog
	initial begin
		repeat (WATCH_CYCLES) @(posedge sys_clk);
		$display("timeout: run did not end within %0d clock periods", WATCH_CYCLES);
		$display("Checks failed");
		$finish;
	end

endmodule

// ==== sim.f ====
+incdir+logic
logic/tmu_pkg.sv
logic/tmu_edge_setup.sv
logic/tmu_geninterp.sv
logic/tmu_vinterp.sv
logic/tmu_coord_clamp.sv
logic/tmu_vertical.sv
dv/tmu_vertical_props.sv
dv/tmu_vertical_tb.sv

// ==== Makefile ====
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -Wno-fatal
TOP       := tmu_vertical_tb
FILELIST  := sim.f
BUILD_DIR := obj_dir
LOG       := sim.log
FAIL_MSG  := Checks failed
PASS_MSG  := All checks passed

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

run: compile
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "simulation ended without a result"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
